// ==== src/bsdf_defines.svh ====
`ifndef BSDF_DEFINES_SVH
`define BSDF_DEFINES_SVH

// Batch geometry
`define DEPTH 8
`define M_BITS 4

// Datapath widths
`define ACC_W 16
`define OUT_W 12

// Leak of the recursion and scaling of the combined result
`define ALPHA_SHIFT 3
`define OUT_SHIFT 3

// Signed weight of each control bit
`define GAMMA0 150
`define GAMMA1 300
`define GAMMA2 600
`define GAMMA3 1200

`endif

// ==== src/bsdfPkg.sv ====
`default_nettype none

`include "bsdf_defines.svh"

package bsdfPkg;

    // One set of control decisions
    typedef logic [`M_BITS-1:0] sample_t;

    // Recursion state and partial result
    typedef logic signed [`ACC_W-1:0] acc_t;

    // Offset binary output word
    typedef logic [`OUT_W-1:0] out_t;

    typedef logic [$clog2(`DEPTH)-1:0] slot_t;
    typedef logic bank2_t;
    typedef logic [1:0] bank3_t;

    typedef enum logic [1:0] {FILL0, FILL1, RUN} ctrlState_t;

endpackage

`default_nettype wire

// ==== src/batchIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface batchIf
    import bsdfPkg::*;
();

    logic   step;
    slot_t  slot;
    slot_t  slotRev;
    logic   firstRev;
    bank2_t wrBank2;
    bank2_t rdBank2;
    bank3_t fwdBank3;
    bank3_t oldBank3;
    logic   run;

    modport ctrl (output step, slot, slotRev, firstRev, wrBank2, rdBank2,
                  fwdBank3, oldBank3, run);
    modport store (input step, slot, slotRev, wrBank2, rdBank2);
    modport result (input step, slot);
    modport unit (input step);
    modport comb (input step, run);

endinterface

`default_nettype wire

// ==== src/batchControl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bsdf_defines.svh"

module batchControl
    import bsdfPkg::*;
(
    input  wire  clkDS,
    input  wire  rst,
    input  wire  inValid,
    input  wire  outValid,
    input  wire  outReady,
    output logic inReady,
    batchIf.ctrl ctl
);

    ctrlState_t state;
    slot_t      slot;
    bank2_t     wrBank2;
    bank3_t     fwdBank3;
    bank3_t     oldBank3;
    logic       step;
    logic       lastSlot;

    function automatic bank3_t bump3(input bank3_t b);
        return (b == 2'd2) ? 2'd0 : b + 2'd1;
    endfunction

    // Only the output register can stall the pipeline
    assign inReady  = !outValid || outReady;
    assign step     = inValid && inReady;
    assign lastSlot = (slot == slot_t'(`DEPTH - 1));

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            state    <= FILL0;
            slot     <= '0;
            wrBank2  <= 1'b0;
            fwdBank3 <= 2'd0;
            // Two periods back from period 0
            oldBank3 <= 2'd1;
        end else if (step) begin
            if (lastSlot) begin
                slot     <= '0;
                wrBank2  <= ~wrBank2;
                fwdBank3 <= bump3(fwdBank3);
                oldBank3 <= bump3(oldBank3);
                case (state)
                    FILL0:   state <= FILL1;
                    default: state <= RUN;
                endcase
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

    assign ctl.step     = step;
    assign ctl.slot     = slot;
    assign ctl.slotRev  = slot_t'(`DEPTH - 1) - slot;
    assign ctl.firstRev = (slot == '0);
    assign ctl.wrBank2  = wrBank2;
    assign ctl.rdBank2  = ~wrBank2;
    assign ctl.fwdBank3 = fwdBank3;
    assign ctl.oldBank3 = oldBank3;
    assign ctl.run      = (state == RUN);

endmodule

`default_nettype wire

// ==== src/sampleBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bsdf_defines.svh"

module sampleBuffer
    import bsdfPkg::*;
(
    input  wire     clkDS,
    input  wire     rst,
    batchIf.store   ctl,
    input  wire sample_t inData,
    output sample_t revSample
);

    sample_t    mem [2][`DEPTH];
    logic [1:0] filled;

    always_ff @(posedge clkDS) begin
        if (ctl.step) begin
            mem[ctl.wrBank2][ctl.slot] <= inData;
        end
    end

    // A bank counts as filled once its last slot has been written
    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            filled <= 2'b00;
        end else if (ctl.step && (ctl.slot == slot_t'(`DEPTH - 1))) begin
            filled[ctl.wrBank2] <= 1'b1;
        end
    end

    // Previous batch read newest sample first
    assign revSample = filled[ctl.rdBank2] ? mem[ctl.rdBank2][ctl.slotRev] : '0;

endmodule

`default_nettype wire

// ==== src/recursionUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bsdf_defines.svh"

module recursionUnit
    import bsdfPkg::*;
(
    input  wire     clkDS,
    input  wire     rst,
    batchIf.unit    ctl,
    input  wire sample_t sample,
    input  wire     clearState,
    output acc_t    stateNext
);

    localparam acc_t GAMMA [`M_BITS] = '{
        acc_t'(`GAMMA0),
        acc_t'(`GAMMA1),
        acc_t'(`GAMMA2),
        acc_t'(`GAMMA3)
    };

    acc_t state;
    acc_t base;
    acc_t lut;

    // Each decision adds or removes its weight
    always_comb begin
        lut = '0;
        for (int i = 0; i < `M_BITS; i++) begin
            if (sample[i]) begin
                lut = lut + GAMMA[i];
            end else begin
                lut = lut - GAMMA[i];
            end
        end
    end

    // Leaky update wrapping at ACC_W
    assign base      = clearState ? '0 : state;
    assign stateNext = base - (base >>> `ALPHA_SHIFT) + lut;

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            state <= '0;
        end else if (ctl.step) begin
            state <= stateNext;
        end
    end

endmodule

`default_nettype wire

// ==== src/resultBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bsdf_defines.svh"

module resultBuffer
    import bsdfPkg::*;
#(
    parameter int BANKS = 2
) (
    input  wire     clkDS,
    batchIf.result  ctl,
    input  wire     wrEn,
    input  wire [$clog2(BANKS)-1:0] wrBank,
    input  wire slot_t wrAddr,
    input  wire acc_t  wrData,
    input  wire [$clog2(BANKS)-1:0] rdBank,
    output acc_t    rdData
);

    acc_t mem [BANKS][`DEPTH];

    always_ff @(posedge clkDS) begin
        if (ctl.step && wrEn) begin
            mem[wrBank][wrAddr] <= wrData;
        end
    end

    // Readout always follows the forward slot order
    assign rdData = mem[rdBank][ctl.slot];

endmodule

`default_nettype wire

// ==== src/outputCombine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bsdf_defines.svh"

module outputCombine
    import bsdfPkg::*;
(
    input  wire      clkDS,
    input  wire      rst,
    batchIf.comb     ctl,
    input  wire acc_t fwd,
    input  wire acc_t bwd,
    input  wire      outReady,
    output out_t     out,
    output logic     outValid
);

    localparam int SAT_MAX = (1 << (`OUT_W - 1)) - 1;
    localparam int SAT_MIN = -(1 << (`OUT_W - 1));

    logic signed [`ACC_W:0] sum;
    logic signed [`ACC_W:0] scaled;
    out_t sat;
    out_t outNext;

    always_comb begin
        // One extra bit so the sum never wraps
        sum    = fwd + bwd;
        scaled = sum >>> `OUT_SHIFT;
        if (scaled > SAT_MAX) begin
            sat = {1'b0, {(`OUT_W - 1){1'b1}}};
        end else if (scaled < SAT_MIN) begin
            sat = {1'b1, {(`OUT_W - 1){1'b0}}};
        end else begin
            sat = scaled[`OUT_W-1:0];
        end
        // Offset binary
        outNext = {~sat[`OUT_W-1], sat[`OUT_W-2:0]};
    end

    always_ff @(posedge clkDS) begin
        if (ctl.step && ctl.run) begin
            out <= outNext;
        end
    end

    always_ff @(posedge clkDS or negedge rst) begin
        if (!rst) begin
            outValid <= 1'b0;
        end else if (ctl.step && ctl.run) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/batchFilterTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module batchFilterTop
    import bsdfPkg::*;
(
    input  wire          clkDS,
    input  wire          rst,
    input  wire sample_t inData,
    input  wire          inValid,
    output logic         inReady,
    output out_t         out,
    output logic         outValid,
    input  wire          outReady
);

    sample_t revSample;
    acc_t    fwdState;
    acc_t    bwdState;
    acc_t    fwdOld;
    acc_t    bwdOld;

    batchIf ifc ();

    batchControl ctrl (
        .clkDS(clkDS), .rst(rst), .inValid(inValid), .outValid(outValid),
        .outReady(outReady), .inReady(inReady), .ctl(ifc)
    );

    sampleBuffer samples (
        .clkDS(clkDS), .rst(rst), .ctl(ifc), .inData(inData), .revSample(revSample)
    );

    // Forward runs on the live stream, backward on the stored batch
    recursionUnit fwdRec (
        .clkDS(clkDS), .rst(rst), .ctl(ifc), .sample(inData),
        .clearState(1'b0), .stateNext(fwdState)
    );

    recursionUnit bwdRec (
        .clkDS(clkDS), .rst(rst), .ctl(ifc), .sample(revSample),
        .clearState(ifc.firstRev), .stateNext(bwdState)
    );

    resultBuffer #(.BANKS(3)) fwdStore (
        .clkDS(clkDS), .ctl(ifc), .wrEn(1'b1), .wrBank(ifc.fwdBank3), .wrAddr(ifc.slot),
        .wrData(fwdState), .rdBank(ifc.oldBank3), .rdData(fwdOld)
    );

    // Backward results of the previous batch are read one period later
    resultBuffer #(.BANKS(2)) bwdStore (
        .clkDS(clkDS), .ctl(ifc), .wrEn(1'b1), .wrBank(ifc.rdBank2), .wrAddr(ifc.slotRev),
        .wrData(bwdState), .rdBank(ifc.wrBank2), .rdData(bwdOld)
    );

    outputCombine combine (
        .clkDS(clkDS), .rst(rst), .ctl(ifc), .fwd(fwdOld), .bwd(bwdOld),
        .outReady(outReady), .out(out), .outValid(outValid)
    );

endmodule

`default_nettype wire

// ==== testbench/batchFilter_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bsdf_defines.svh"

module batchFilter_assertions (
    input wire              clkDS,
    input wire              rst,
    input wire              inReady,
    input wire              outValid,
    input wire              outReady,
    input wire [`OUT_W-1:0] held
);

    // Output word stays valid until it is taken
    assert property (@(posedge clkDS) disable iff (!rst)
        (outValid && !outReady) |=> outValid)
        else $error("outValid dropped while stalled");

    // Pipeline frozen while the input side is not ready
    assert property (@(posedge clkDS) disable iff (!rst)
        !inReady |=> $stable(held))
        else $error("state changed while inReady low");

    // First edge after reset release
    assert property (@(posedge clkDS) $rose(rst) |-> (inReady && !outValid))
        else $error("handshake not idle after reset");

endmodule

bind batchControl batchFilter_assertions ctrlChecks (
    .clkDS(clkDS), .rst(rst), .inReady(inReady), .outValid(outValid),
    .outReady(outReady), .held(`OUT_W'(slot))
);

bind outputCombine batchFilter_assertions combChecks (
    .clkDS(clkDS), .rst(rst), .inReady(!outValid || outReady), .outValid(outValid),
    .outReady(outReady), .held(out)
);

`default_nettype wire

// ==== testbench/batchFilterTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bsdf_defines.svh"

module batchFilterTb
    import bsdfPkg::*;
;

    localparam int NB     = 5;
    localparam int PERIOD = 20;
    localparam int WORDS  = NB * 2 * `DEPTH;
    localparam int LIMIT  = 3 * (NB * `DEPTH * 4 + 16) * PERIOD + 2000;

    logic [`OUT_W-1:0] golden [WORDS];
    logic    clkDS;
    logic    rst;
    sample_t inData;
    logic    inValid;
    logic    inReady;
    out_t    out;
    logic    outValid;
    logic    outReady;

    int   seed;
    int   errors;
    int   inCount;
    int   outCount;
    int   cycle;
    bit   steadyMode;
    out_t expQ [$];
    int   hsQ [$];

    batchFilterTop DUT (
        .clkDS(clkDS), .rst(rst), .inData(inData), .inValid(inValid),
        .inReady(inReady), .out(out), .outValid(outValid), .outReady(outReady)
    );

    initial clkDS = 1'b0;
    always #(PERIOD / 2) clkDS = ~clkDS;

    // Handshake monitor picking the expected value from the period's line
    always @(posedge clkDS) begin
        out_t expVal;
        int   hsCycle;
        if (rst && inValid && inReady) begin
            if (inCount >= 2 * `DEPTH) begin
                expQ.push_back(golden[(inCount / `DEPTH) * 2 * `DEPTH + `DEPTH
                                      + inCount % `DEPTH]);
                hsQ.push_back(cycle);
            end
            inCount++;
        end
        if (rst && outValid && outReady) begin
            if (expQ.size() == 0) begin
                $display("Output transfer at %0t with no output due (warm-up or extra)", $time);
                errors++;
            end else begin
                expVal  = expQ.pop_front();
                hsCycle = hsQ.pop_front();
                if (out !== expVal) begin
                    $display("Mismatch at %0t: output %0d expected %h got %h",
                             $time, outCount, expVal, out);
                    errors++;
                end
                if (steadyMode && cycle != hsCycle + 1) begin
                    $display("Output %0d at %0t not one cycle after its input",
                             outCount, $time);
                    errors++;
                end
            end
            outCount++;
        end
        cycle++;
    end

    task automatic applyReset();
        rst      = 1'b0;
        inValid  = 1'b0;
        outReady = 1'b0;
        repeat (16) @(posedge clkDS);
        @(negedge clkDS);
        expQ.delete();
        hsQ.delete();
        inCount  = 0;
        outCount = 0;
        rst      = 1'b1;
        @(negedge clkDS);
        if (outValid !== 1'b0 || inReady !== 1'b1) begin
            $display("Handshake not idle after reset at %0t", $time);
            errors++;
        end
    endtask

    function automatic bit chance(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    task automatic runStream(input string name, input int gapPct, input int stallPct);
        int  startErrors;
        int  k;
        int  drain;
        bit  accepted;
        startErrors = errors;
        applyReset();
        for (k = 0; k < NB * `DEPTH; k++) begin
            outReady = !chance(stallPct);
            while (chance(gapPct)) begin
                inValid = 1'b0;
                @(negedge clkDS);
                outReady = !chance(stallPct);
            end
            inValid = 1'b1;
            inData  = sample_t'(golden[(k / `DEPTH) * 2 * `DEPTH + k % `DEPTH]);
            do begin
                @(posedge clkDS);
                accepted = inReady;
                @(negedge clkDS);
                if (!accepted) begin
                    outReady = !chance(stallPct);
                end
            end while (!accepted);
        end
        inValid  = 1'b0;
        outReady = 1'b1;
        for (drain = 0; drain < 20 && expQ.size() != 0; drain++) begin
            @(negedge clkDS);
        end
        if (expQ.size() != 0) begin
            $display("Test %s lost %0d outputs", name, expQ.size());
            errors++;
        end
        if (outCount != inCount - 2 * `DEPTH) begin
            $display("Test %s: %0d outputs for %0d inputs", name, outCount, inCount);
            errors++;
        end
        $display("Test %s done: %0d inputs, %0d outputs, %0d errors",
                 name, inCount, outCount, errors - startErrors);
    endtask

    initial begin
        rst        = 1'b0;
        inData     = '0;
        inValid    = 1'b0;
        outReady   = 1'b0;
        seed       = 32'hc133_7927;
        errors     = 0;
        inCount    = 0;
        outCount   = 0;
        cycle      = 0;
        steadyMode = 1'b0;
        $readmemh("testbench/batchFilter_golden.mem", golden);
        steadyMode = 1'b1;
        runStream("steady", 0, 0);
        steadyMode = 1'b0;
        runStream("backpressure", 0, 50);
        runStream("gaps", 40, 0);
        $display("Summary: 3 tests, %0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(LIMIT);
        $display("Timeout: the tests did not finish in time");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+src
src/bsdfPkg.sv
src/batchIf.sv
src/batchControl.sv
src/sampleBuffer.sv
src/recursionUnit.sv
src/resultBuffer.sv
src/outputCombine.sv
src/batchFilterTop.sv
testbench/batchFilter_assertions.sv
testbench/batchFilterTb.sv

// ==== Bender.yml ====
package:
  name: batch_filter

sources:
  - include_dirs:
      - src
    files:
      - src/bsdfPkg.sv
      - src/batchIf.sv
      - src/batchControl.sv
      - src/sampleBuffer.sv
      - src/recursionUnit.sv
      - src/resultBuffer.sv
      - src/outputCombine.sv
      - src/batchFilterTop.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - testbench/batchFilter_assertions.sv
      - testbench/batchFilterTb.sv

// ==== testbench/batchFilter_golden.mem ====
// Columns: DEPTH input codes, then DEPTH expected offset-binary outputs of that period
// Outputs on a line belong to the batch two lines earlier
8 8 A C 7 5 8 7 000 000 000 000 000 000 000 000
3 7 8 A 8 8 5 C 000 000 000 000 000 000 000 000
7 7 8 8 A A 5 3 8B5 8C7 922 968 87D 80B 86F 839
1 2 3 4 5 6 7 8 75B 80D 854 8BC 877 87A 809 92A
F E D C B A 9 0 851 846 867 85F 89F 87B 783 714
